// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN        = 32; // Data and address width.
  localparam int UOP_COUNT_W = 5;  // Micro-op counter width.
  localparam int REG_PC      = 31; // r31 holds the program counter.
  localparam int PC_STEP     = 4;  // Bytes per instruction word.

  // Instruction opcodes, taken from opword bits 31:26.
  typedef enum logic [5:0] {
    OP_RESET = 6'd0,
    OP_FETCH = 6'd1,
    OP_LHU   = 6'd2, // rD = zeroext(I).
    OP_ADDU  = 6'd3, // rD = rS + zeroext(I).
    OP_ADD3  = 6'd4, // rD = rA + rB.
    OP_SW    = 6'd5, // mem[rD] = rS.
    OP_OR3   = 6'd6, // rD = rA | rB.
    OP_LH    = 6'd7, // rD = signext(I).
    OP_BEQ   = 6'd8  // if rA == rB then PC += signext(I).
  } opcode_e;

  // Bus sources. Code 7 was the timer and stays unused.
  typedef enum logic [3:0] {
    OUT_NONE             = 4'd0,
    OUT_REG              = 4'd1,
    OUT_TMP0             = 4'd2,
    OUT_TMP1             = 4'd3,
    OUT_MMU              = 4'd4,
    OUT_MLU              = 4'd5,
    OUT_SHIFTER          = 4'd6,
    OUT_CTRL_DATA        = 4'd8,
    OUT_OPWORD_IMMEDIATE = 4'd9
  } out_plane_e;

  // Bus destinations.
  typedef enum logic [2:0] {
    IN_NONE   = 3'd0,
    IN_REG    = 3'd1,
    IN_TMP0   = 3'd2,
    IN_TMP1   = 3'd3,
    IN_MMU    = 3'd4,
    IN_OPWORD = 3'd5,
    IN_OPCODE = 3'd6
  } in_plane_e;

  typedef enum logic [1:0] {
    REG_SEL_OPWORD0, // Opword bits 25:21.
    REG_SEL_OPWORD1, // Opword bits 20:16.
    REG_SEL_OPWORD2, // Opword bits 15:11.
    REG_SEL_CONTROL  // Low bits of ctrl_data.
  } reg_sel_e;

  typedef enum logic [2:0] {MLU_ADD, MLU_SUB, MLU_OR} mlu_op_e;

  typedef enum logic [1:0] {SHIFTER_PASS, SHIFTER_SIGNEXT16} shifter_plane_e;

  typedef enum logic [1:0] {COND_ZERO, COND_CARRY, COND_NEGATIVE} cond_sel_e;

  typedef enum logic {OPSEL_FROM_OPWORD, OPSEL_FROM_BUS} opcode_sel_e;

endpackage

`default_nettype wire

// File: verilog/ctrl_word_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ctrl_word_if import cpu_pkg::*; (input logic clk);

  logic [5:0]     ctrl_data;     // Constant, register number or opcode.
  reg_sel_e       reg_sel;
  out_plane_e     out_plane;
  in_plane_e      in_plane;
  logic           reset_uop;     // Misc plane, restarts the micro-op counter.
  mlu_op_e        mlu_op;
  logic           mlu_carry;     // Carry into the adder.
  shifter_plane_e shifter_plane;
  opcode_sel_e    opcode_sel;
  cond_sel_e      cond_sel;

  modport decoder (output ctrl_data, reg_sel, out_plane, in_plane, reset_uop, mlu_op,
                   mlu_carry, shifter_plane, opcode_sel, cond_sel);
  modport sequencer (input ctrl_data, in_plane, reset_uop, opcode_sel, cond_sel);
  modport execute (input ctrl_data, reg_sel, out_plane, in_plane, reset_uop, mlu_op,
                   mlu_carry, shifter_plane);

endinterface

`default_nettype wire

// File: verilog/microcode_rom.sv
`timescale 1ns/10ps
`default_nettype none

module microcode_rom import cpu_pkg::*; (
  input  logic                   cond_var,
  input  opcode_e                opcode,
  input  logic [UOP_COUNT_W-1:0] uop_count,
  ctrl_word_if.decoder           ctrl
);

  logic go_fetch; // Selects the shared fetch-return step.

  always_comb begin
    ctrl.ctrl_data     = '0;
    ctrl.reg_sel       = REG_SEL_OPWORD0;
    ctrl.out_plane     = OUT_NONE;
    ctrl.in_plane      = IN_NONE;
    ctrl.reset_uop     = 1'b0;
    ctrl.mlu_op        = MLU_ADD;
    ctrl.mlu_carry     = 1'b0;
    ctrl.shifter_plane = SHIFTER_PASS;
    ctrl.opcode_sel    = OPSEL_FROM_OPWORD;
    ctrl.cond_sel      = COND_ZERO;
    go_fetch           = 1'b0;
    case (opcode)
      OP_RESET: begin
        case (uop_count)
          5'd0: begin // NONE drives zero onto PC.
            ctrl.ctrl_data = 6'(REG_PC);
            ctrl.reg_sel   = REG_SEL_CONTROL;
            ctrl.in_plane  = IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      OP_FETCH: begin
        case (uop_count)
          5'd0: begin // PC into TMP0 as the read address.
            ctrl.ctrl_data = 6'(REG_PC);
            ctrl.reg_sel   = REG_SEL_CONTROL;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_TMP0;
          end
          5'd1: begin // Instruction word into the opword.
            ctrl.out_plane = OUT_MMU;
            ctrl.in_plane  = IN_OPWORD;
          end
          5'd2: begin // Step size into TMP1.
            ctrl.ctrl_data = 6'(PC_STEP);
            ctrl.out_plane = OUT_CTRL_DATA;
            ctrl.in_plane  = IN_TMP1;
          end
          5'd3: begin // PC = TMP0 + TMP1.
            ctrl.ctrl_data = 6'(REG_PC);
            ctrl.reg_sel   = REG_SEL_CONTROL;
            ctrl.out_plane = OUT_MLU;
            ctrl.in_plane  = IN_REG;
          end
          default: begin // Dispatch on the opword opcode.
            ctrl.in_plane   = IN_OPCODE;
            ctrl.reset_uop  = 1'b1;
            ctrl.opcode_sel = OPSEL_FROM_OPWORD;
          end
        endcase
      end
      OP_LHU: begin
        if (uop_count == 5'd0) begin // Zero-extended immediate straight to rD.
          ctrl.out_plane = OUT_OPWORD_IMMEDIATE;
          ctrl.in_plane  = IN_REG;
        end else begin
          go_fetch = 1'b1;
        end
      end
      OP_LH: begin
        case (uop_count)
          5'd0: begin
            ctrl.out_plane = OUT_OPWORD_IMMEDIATE;
            ctrl.in_plane  = IN_TMP0;
          end
          5'd1: begin // Sign-extended copy into rD.
            ctrl.out_plane     = OUT_SHIFTER;
            ctrl.shifter_plane = SHIFTER_SIGNEXT16;
            ctrl.in_plane      = IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      OP_SW: begin
        case (uop_count)
          5'd0: begin // rD is address.
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_TMP0;
          end
          5'd1: begin // rS onto the bus and out to memory.
            ctrl.reg_sel   = REG_SEL_OPWORD1;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_MMU;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      OP_ADDU, OP_ADD3, OP_OR3: begin
        case (uop_count)
          5'd0: begin // rS or rA into TMP0.
            ctrl.reg_sel   = REG_SEL_OPWORD1;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_TMP0;
          end
          5'd1: begin // Immediate or rB into TMP1.
            ctrl.reg_sel   = REG_SEL_OPWORD2;
            ctrl.out_plane = (opcode == OP_ADDU) ? OUT_OPWORD_IMMEDIATE : OUT_REG;
            ctrl.in_plane  = IN_TMP1;
          end
          5'd2: begin // Result into rD.
            ctrl.out_plane = OUT_MLU;
            ctrl.in_plane  = IN_REG;
            ctrl.mlu_op    = (opcode == OP_OR3) ? MLU_OR : MLU_ADD;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      OP_BEQ: begin
        case (uop_count)
          5'd0: begin // rA.
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_TMP0;
          end
          5'd1: begin // rB into TMP1.
            ctrl.reg_sel   = REG_SEL_OPWORD1;
            ctrl.out_plane = OUT_REG;
            ctrl.in_plane  = IN_TMP1;
          end
          5'd2: begin // Compare, zero flag is looked at next.
            ctrl.mlu_op    = MLU_SUB;
            ctrl.mlu_carry = 1'b1;
            ctrl.cond_sel  = COND_ZERO;
          end
          5'd3: begin
            if (cond_var) begin // Equal, offset into TMP0.
              ctrl.out_plane = OUT_OPWORD_IMMEDIATE;
              ctrl.in_plane  = IN_TMP0;
            end else begin
              go_fetch = 1'b1; // Not taken.
            end
          end
          5'd4: ctrl.in_plane = IN_TMP1; // Clear TMP1.
          5'd5: begin // Sign-extended offset into TMP1.
            ctrl.out_plane     = OUT_SHIFTER;
            ctrl.shifter_plane = SHIFTER_SIGNEXT16;
            ctrl.in_plane      = IN_TMP1;
          end
          5'd6, 5'd7: begin // Load PC, then PC = PC + offset.
            ctrl.ctrl_data = 6'(REG_PC);
            ctrl.reg_sel   = REG_SEL_CONTROL;
            ctrl.out_plane = (uop_count == 5'd6) ? OUT_REG : OUT_MLU;
            ctrl.in_plane  = (uop_count == 5'd6) ? IN_TMP0 : IN_REG;
          end
          default: go_fetch = 1'b1;
        endcase
      end
      default: go_fetch = 1'b1; // Unknown opcodes act as no-ops.
    endcase
    if (go_fetch) begin // Opcode = FETCH via the bus, counter back to 0.
      ctrl.ctrl_data  = OP_FETCH;
      ctrl.out_plane  = OUT_CTRL_DATA;
      ctrl.in_plane   = IN_OPCODE;
      ctrl.reset_uop  = 1'b1;
      ctrl.opcode_sel = OPSEL_FROM_BUS;
    end
  end

endmodule

`default_nettype wire

// File: verilog/microcode_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module microcode_sequencer import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  ctrl_word_if.sequencer         ctrl,
  input  logic                   stall,
  input  logic                   mlu_zero,
  input  logic                   mlu_carry_out,
  input  logic                   mlu_negative,
  input  logic [5:0]             bus_opcode,
  input  logic [5:0]             opword_opcode,
  output opcode_e                opcode,
  output logic [UOP_COUNT_W-1:0] uop_count,
  output logic                   cond_var
);

  logic [5:0] next_opcode; // Value loaded on an OPCODE write.
  logic       cond_flag;   // Flag picked by cond_sel.

  assign next_opcode = (ctrl.opcode_sel == OPSEL_FROM_BUS) ? bus_opcode : opword_opcode;

  always_comb begin
    case (ctrl.cond_sel)
      COND_CARRY:    cond_flag = mlu_carry_out;
      COND_NEGATIVE: cond_flag = mlu_negative;
      default:       cond_flag = mlu_zero;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      opcode    <= OP_RESET; // Start with the reset sequence.
      uop_count <= '0;
      cond_var  <= 1'b0;
    end else if (!stall) begin // Everything holds while memory is busy.
      uop_count <= ctrl.reset_uop ? '0 : uop_count + 1'b1;
      cond_var  <= cond_flag; // Seen by the next micro-op.
      if (ctrl.in_plane == IN_OPCODE) begin
        opcode <= opcode_e'(next_opcode); // Unlisted codes fall to the fetch step.
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import cpu_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  ctrl_word_if.execute    ctrl,
  input  logic            stall,
  input  logic [XLEN-1:0] mem_rdata,
  output logic            mem_rd_req,
  output logic            mem_wr_req,
  output logic [XLEN-1:0] mem_addr,
  output logic [XLEN-1:0] mem_wdata,
  output logic            mlu_zero,
  output logic            mlu_carry_out,
  output logic            mlu_negative,
  output logic [5:0]      bus_opcode,
  output logic [5:0]      opword_opcode
);

  logic [XLEN-1:0] regs [32];  // r31 is the PC.
  logic [XLEN-1:0] tmp0;       // MLU A operand and memory address.
  logic [XLEN-1:0] tmp1;       // MLU B operand.
  logic [XLEN-1:0] opword;     // Current instruction word.
  logic [4:0]      reg_addr;
  logic [XLEN-1:0] bus;
  logic [XLEN-1:0] mlu_operand;
  logic [XLEN-1:0] mlu_result;
  logic [XLEN-1:0] shift_result;

  always_comb begin
    case (ctrl.reg_sel)
      REG_SEL_OPWORD0: reg_addr = opword[25:21];
      REG_SEL_OPWORD1: reg_addr = opword[20:16];
      REG_SEL_OPWORD2: reg_addr = opword[15:11];
      default:         reg_addr = ctrl.ctrl_data[4:0];
    endcase
  end

  // Subtract is A + ~B + carry-in.
  assign mlu_operand = (ctrl.mlu_op == MLU_SUB) ? ~tmp1 : tmp1;

  always_comb begin
    if (ctrl.mlu_op == MLU_OR) begin
      mlu_carry_out = 1'b0;
      mlu_result    = tmp0 | tmp1;
    end else begin
      {mlu_carry_out, mlu_result} = {1'b0, tmp0} + {1'b0, mlu_operand}
                                    + (XLEN + 1)'(ctrl.mlu_carry);
    end
  end

  assign mlu_zero     = (mlu_result == '0);
  assign mlu_negative = mlu_result[XLEN-1];

  assign shift_result = (ctrl.shifter_plane == SHIFTER_SIGNEXT16) ?
                        {{(XLEN - 16){tmp0[15]}}, tmp0[15:0]} : tmp0;

  always_comb begin
    case (ctrl.out_plane)
      OUT_REG:              bus = regs[reg_addr];
      OUT_TMP0:             bus = tmp0;
      OUT_TMP1:             bus = tmp1;
      OUT_MMU:              bus = mem_rdata;
      OUT_MLU:              bus = mlu_result;
      OUT_SHIFTER:          bus = shift_result;
      OUT_CTRL_DATA:        bus = XLEN'(ctrl.ctrl_data);
      OUT_OPWORD_IMMEDIATE: bus = XLEN'(opword[15:0]); // Zero-extended.
      default:              bus = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0; // PC starts at 0.
      end
    end else if (!stall && ctrl.in_plane == IN_REG) begin
      regs[reg_addr] <= bus;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      case (ctrl.in_plane)
        IN_TMP0:   tmp0   <= bus;
        IN_TMP1:   tmp1   <= bus;
        IN_OPWORD: opword <= bus;
        default: ;
      endcase
    end
  end

  // Requests follow the current micro-op.
  assign mem_rd_req    = (ctrl.out_plane == OUT_MMU);
  assign mem_wr_req    = (ctrl.in_plane == IN_MMU);
  assign mem_addr      = tmp0;
  assign mem_wdata     = bus;
  assign bus_opcode    = bus[5:0];
  assign opword_opcode = opword[31:26];

endmodule

`default_nettype wire

// File: verilog/mem_axi_master.sv
`timescale 1ns/10ps
`default_nettype none

module mem_axi_master import cpu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              rd_req,
  input  logic              wr_req,
  input  logic [XLEN-1:0]   addr,
  input  logic [XLEN-1:0]   wdata,
  output logic [XLEN-1:0]   rdata,
  output logic              stall,
  output logic [XLEN-1:0]   axi_awaddr,
  output logic              axi_awvalid,
  input  logic              axi_awready,
  output logic [XLEN-1:0]   axi_wdata,
  output logic [XLEN/8-1:0] axi_wstrb,
  output logic              axi_wvalid,
  input  logic              axi_wready,
  input  logic [1:0]        axi_bresp,
  input  logic              axi_bvalid,
  output logic              axi_bready,
  output logic [XLEN-1:0]   axi_araddr,
  output logic              axi_arvalid,
  input  logic              axi_arready,
  input  logic [XLEN-1:0]   axi_rdata,
  input  logic [1:0]        axi_rresp,
  input  logic              axi_rvalid,
  output logic              axi_rready
);

  typedef enum logic [1:0] {IDLE, WRITE, READ} state_e;

  state_e          state;
  logic [XLEN-1:0] addr_q; // Shared by AW and AR.

  assign axi_awaddr = addr_q;
  assign axi_araddr = addr_q;
  assign axi_wstrb  = '1;   // Word accesses only.
  assign axi_bready = 1'b1;
  assign axi_rready = 1'b1;
  assign rdata      = axi_rdata; // Sampled by the core in the R cycle.

  always_comb begin
    case (state)
      IDLE:    stall = rd_req | wr_req; // First cycle of a request.
      WRITE:   stall = !axi_bvalid;
      READ:    stall = !axi_rvalid;
      default: stall = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      axi_awvalid <= 1'b0;
      axi_wvalid  <= 1'b0;
      axi_arvalid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_req) begin
            state       <= WRITE;
            axi_awvalid <= 1'b1; // AW and W go up together.
            axi_wvalid  <= 1'b1;
          end else if (rd_req) begin
            state       <= READ;
            axi_arvalid <= 1'b1;
          end
        end
        WRITE: begin
          if (axi_awready) axi_awvalid <= 1'b0;
          if (axi_wready)  axi_wvalid  <= 1'b0;
          if (axi_bvalid)  state       <= IDLE; // Response code is ignored.
        end
        READ: begin
          if (axi_arready) axi_arvalid <= 1'b0;
          if (axi_rvalid)  state       <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin // Payload frozen once valid is up.
      addr_q    <= addr;
      axi_wdata <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  output logic [XLEN-1:0]   axi_awaddr,
  output logic              axi_awvalid,
  input  logic              axi_awready,
  output logic [XLEN-1:0]   axi_wdata,
  output logic [XLEN/8-1:0] axi_wstrb,
  output logic              axi_wvalid,
  input  logic              axi_wready,
  input  logic [1:0]        axi_bresp,
  input  logic              axi_bvalid,
  output logic              axi_bready,
  output logic [XLEN-1:0]   axi_araddr,
  output logic              axi_arvalid,
  input  logic              axi_arready,
  input  logic [XLEN-1:0]   axi_rdata,
  input  logic [1:0]        axi_rresp,
  input  logic              axi_rvalid,
  output logic              axi_rready
);

  opcode_e                opcode;
  logic [UOP_COUNT_W-1:0] uop_count;
  logic                   cond_var;
  logic                   stall;        // Memory busy, freezes the core.
  logic                   mlu_zero;
  logic                   mlu_carry_out;
  logic                   mlu_negative;
  logic [5:0]             bus_opcode;
  logic [5:0]             opword_opcode;
  logic                   mem_rd_req;
  logic                   mem_wr_req;
  logic [XLEN-1:0]        mem_addr;
  logic [XLEN-1:0]        mem_wdata;
  logic [XLEN-1:0]        mem_rdata;

  ctrl_word_if ctrl (.clk(clk));

  microcode_rom u_rom (
    .cond_var (cond_var),
    .opcode   (opcode),
    .uop_count(uop_count),
    .ctrl     (ctrl.decoder)
  );

  microcode_sequencer u_seq (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctrl         (ctrl.sequencer),
    .stall        (stall),
    .mlu_zero     (mlu_zero),
    .mlu_carry_out(mlu_carry_out),
    .mlu_negative (mlu_negative),
    .bus_opcode   (bus_opcode),
    .opword_opcode(opword_opcode),
    .opcode       (opcode),
    .uop_count    (uop_count),
    .cond_var     (cond_var)
  );

  datapath u_dp (
    .clk          (clk),
    .arst_n       (arst_n),
    .ctrl         (ctrl.execute),
    .stall        (stall),
    .mem_rdata    (mem_rdata),
    .mem_rd_req   (mem_rd_req),
    .mem_wr_req   (mem_wr_req),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mlu_zero     (mlu_zero),
    .mlu_carry_out(mlu_carry_out),
    .mlu_negative (mlu_negative),
    .bus_opcode   (bus_opcode),
    .opword_opcode(opword_opcode)
  );

  mem_axi_master u_mem (
    .clk        (clk),
    .arst_n     (arst_n),
    .rd_req     (mem_rd_req),
    .wr_req     (mem_wr_req),
    .addr       (mem_addr),
    .wdata      (mem_wdata),
    .rdata      (mem_rdata),
    .stall      (stall),
    .axi_awaddr (axi_awaddr),
    .axi_awvalid(axi_awvalid),
    .axi_awready(axi_awready),
    .axi_wdata  (axi_wdata),
    .axi_wstrb  (axi_wstrb),
    .axi_wvalid (axi_wvalid),
    .axi_wready (axi_wready),
    .axi_bresp  (axi_bresp),
    .axi_bvalid (axi_bvalid),
    .axi_bready (axi_bready),
    .axi_araddr (axi_araddr),
    .axi_arvalid(axi_arvalid),
    .axi_arready(axi_arready),
    .axi_rdata  (axi_rdata),
    .axi_rresp  (axi_rresp),
    .axi_rvalid (axi_rvalid),
    .axi_rready (axi_rready)
  );

endmodule

`default_nettype wire

// File: dv/tb_cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  localparam int N_PROG    = 26;
  localparam int N_STORES  = 8;
  localparam int MEM_WORDS = 1024;                 // 4 KB, index is addr[11:2].
  localparam int TIMEOUT   = N_STORES * 40 + 200;  // Cycles after reset.
  localparam int DRAIN     = 80;                   // Several turns of the final spin loop.

  localparam logic [31:0] V_LHU  = 32'h0000_8001;  // 0x8001 zero-extended.
  localparam logic [31:0] V_LH   = 32'hFFFF_8001;  // 0x8001 sign-extended.
  localparam logic [31:0] V_ADDU = V_LHU + 32'h0000_1234;
  localparam logic [31:0] V_ADD3 = V_LH + V_ADDU;
  localparam logic [31:0] V_OR3  = V_LH | V_ADDU;

  logic              clk;
  logic              arst_n;
  logic [XLEN-1:0]   axi_awaddr;
  logic              axi_awvalid;
  logic              axi_awready;
  logic [XLEN-1:0]   axi_wdata;
  logic [XLEN/8-1:0] axi_wstrb;
  logic              axi_wvalid;
  logic              axi_wready;
  logic [1:0]        axi_bresp;
  logic              axi_bvalid;
  logic              axi_bready;
  logic [XLEN-1:0]   axi_araddr;
  logic              axi_arvalid;
  logic              axi_arready;
  logic [XLEN-1:0]   axi_rdata;
  logic [1:0]        axi_rresp;
  logic              axi_rvalid;
  logic              axi_rready;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] program_words [N_PROG];
  logic [31:0] exp_addr [N_STORES];
  logic [31:0] exp_data [N_STORES];
  string       exp_note [N_STORES];
  logic [31:0] rng_state;
  logic [31:0] last_fetch_addr;
  logic [31:0] last_word;       // Instruction at the previous fetch.
  int          fetch_count;
  int          stores_seen;
  int          errors;
  int          cycles;

  cpu_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] enc_imm(opcode_e op, logic [4:0] rd, logic [4:0] rs,
                                          logic [15:0] imm);
    return {op, rd, rs, imm};
  endfunction

  function automatic logic [31:0] enc_reg(opcode_e op, logic [4:0] rd, logic [4:0] ra,
                                          logic [4:0] rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic int unsigned rand_delay();
    rng_state = rng_state ^ (rng_state << 13); // Xorshift32.
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state % 4;                      // 0 to 3 cycles.
  endfunction

  task automatic advance_cycle();
    @(posedge clk);
    #1;                                        // Drive point after the edge.
  endtask

  task automatic build_tables();
    program_words[0]  = enc_imm(OP_LHU, 5'd1, 5'd0, 16'h8001);   // r1 = 0x00008001.
    program_words[1]  = enc_imm(OP_LH, 5'd2, 5'd0, 16'h8001);    // r2 = 0xFFFF8001.
    program_words[2]  = enc_imm(OP_LHU, 5'd10, 5'd0, 16'h0400);  // r10 = store base.
    program_words[3]  = enc_imm(OP_SW, 5'd10, 5'd1, 16'h0);
    program_words[4]  = enc_imm(OP_ADDU, 5'd11, 5'd10, 16'd4);
    program_words[5]  = enc_imm(OP_SW, 5'd11, 5'd2, 16'h0);
    program_words[6]  = enc_imm(OP_ADDU, 5'd3, 5'd1, 16'h1234);  // r3 = r1 + 0x1234.
    program_words[7]  = enc_reg(OP_ADD3, 5'd4, 5'd2, 5'd3);
    program_words[8]  = enc_reg(OP_OR3, 5'd5, 5'd2, 5'd3);
    program_words[9]  = enc_imm(OP_ADDU, 5'd12, 5'd11, 16'd4);
    program_words[10] = enc_imm(OP_SW, 5'd12, 5'd3, 16'h0);
    program_words[11] = enc_imm(OP_ADDU, 5'd13, 5'd12, 16'd4);
    program_words[12] = enc_imm(OP_SW, 5'd13, 5'd4, 16'h0);
    program_words[13] = enc_imm(OP_ADDU, 5'd14, 5'd13, 16'd4);
    program_words[14] = enc_imm(OP_SW, 5'd14, 5'd5, 16'h0);
    program_words[15] = enc_imm(OP_ADDU, 5'd7, 5'd0, 16'h8001);  // r7 equals r1.
    program_words[16] = enc_imm(OP_BEQ, 5'd1, 5'd7, 16'h001C);   // Taken, to 0x60.
    program_words[17] = enc_imm(OP_SW, 5'd10, 5'd0, 16'h0);      // Shadow, never runs.
    program_words[18] = enc_imm(OP_SW, 5'd11, 5'd7, 16'h0);      // Landing at 0x48.
    program_words[19] = enc_imm(OP_BEQ, 5'd1, 5'd2, 16'h0004);   // Not taken.
    program_words[20] = enc_imm(OP_SW, 5'd12, 5'd1, 16'h0);
    program_words[21] = 32'hFC00_0000;                           // Opcode 0x3F.
    program_words[22] = enc_imm(OP_SW, 5'd13, 5'd2, 16'h0);
    program_words[23] = enc_imm(OP_BEQ, 5'd0, 5'd0, 16'hFFFC);   // Spin on itself.
    program_words[24] = enc_imm(OP_BEQ, 5'd0, 5'd0, 16'hFFE4);   // Back to 0x48.
    program_words[25] = enc_imm(OP_SW, 5'd14, 5'd0, 16'h0);      // Shadow, never runs.
    exp_addr[0] = 32'h400;
    exp_data[0] = V_LHU;
    exp_note[0] = "LHU zero-extend";
    exp_addr[1] = 32'h404;
    exp_data[1] = V_LH;
    exp_note[1] = "LH sign-extend";
    exp_addr[2] = 32'h408;
    exp_data[2] = V_ADDU;
    exp_note[2] = "ADDU";
    exp_addr[3] = 32'h40C;
    exp_data[3] = V_ADD3;
    exp_note[3] = "ADD3";
    exp_addr[4] = 32'h410;
    exp_data[4] = V_OR3;
    exp_note[4] = "OR3";
    exp_addr[5] = 32'h404;
    exp_data[5] = V_LHU;
    exp_note[5] = "taken BEQ pair";
    exp_addr[6] = 32'h408;
    exp_data[6] = V_LHU;
    exp_note[6] = "untaken BEQ";
    exp_addr[7] = 32'h40C;
    exp_data[7] = V_LH;
    exp_note[7] = "unknown opcode";
  endtask

  // PC steps by 4, or after a BEQ may also land on PC + 4 + offset.
  task automatic check_fetch(input logic [31:0] addr);
    logic [31:0] next_pc;
    logic [31:0] taken_pc;
    logic        ok;
    next_pc  = (fetch_count == 0) ? 32'h0 : last_fetch_addr + 32'd4;
    taken_pc = next_pc + {{16{last_word[15]}}, last_word[15:0]};
    ok       = (addr == next_pc) ||
               (fetch_count != 0 && last_word[31:26] == OP_BEQ && addr == taken_pc);
    assert (ok) else begin
      $display("ERR araddr: expected %h (or %h after BEQ), got %h", next_pc, taken_pc, addr);
      errors++;
    end
    last_fetch_addr = addr;
    last_word       = mem[addr[11:2]];
    fetch_count++;
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    int idx;
    int bad;
    idx = stores_seen;
    bad = errors;
    stores_seen++;
    assert (idx < N_STORES) else begin
      $display("Unexpected extra store to %h after the last expected one", addr);
      errors++;
    end
    if (idx < N_STORES) begin
      assert (addr == exp_addr[idx]) else begin
        $display("ERR awaddr: expected %h, got %h", exp_addr[idx], addr);
        errors++;
      end
      assert (data == exp_data[idx]) else begin
        $display("ERR wdata: expected %h, got %h", exp_data[idx], data);
        errors++;
      end
      $display("store %0d (%s): %s", idx, exp_note[idx], (errors == bad) ? "ok" : "mismatch");
    end
  endtask

  task automatic serve_write();
    int unsigned aw_wait;
    int unsigned w_wait;
    logic        aw_open;
    logic        w_open;
    logic [31:0] got_addr;
    logic [31:0] got_data;
    aw_wait = rand_delay();
    w_wait  = rand_delay();
    aw_open = 1'b1;
    w_open  = 1'b1;
    while (aw_open || w_open) begin                // AW and W accepted independently.
      axi_awready = aw_open && (aw_wait == 0);
      axi_wready  = w_open && (w_wait == 0);
      if (axi_awready) got_addr = axi_awaddr;
      if (axi_wready) got_data = axi_wdata;
      assert (!axi_wready || axi_wstrb == '1) else begin
        $display("ERR wstrb: expected %h, got %h", 4'hF, axi_wstrb);
        errors++;
      end
      advance_cycle();
      if (axi_awready) aw_open = 1'b0;
      else if (aw_wait != 0) aw_wait--;
      if (axi_wready) w_open = 1'b0;
      else if (w_wait != 0) w_wait--;
    end
    axi_awready = 1'b0;
    axi_wready  = 1'b0;
    axi_bvalid  = 1'b1;                            // OKAY response.
    assert (axi_bready === 1'b1) else begin
      $display("ERR bready: expected %h, got %h", 1'b1, axi_bready);
      errors++;
    end
    advance_cycle();
    axi_bvalid  = 1'b0;
    mem[got_addr[11:2]] = got_data;
    check_store(got_addr, got_data);
  endtask

  task automatic serve_read();
    logic [31:0] addr;
    int unsigned ar_wait;
    int unsigned r_wait;
    ar_wait = rand_delay();
    r_wait  = rand_delay();
    repeat (ar_wait) advance_cycle();
    addr        = axi_araddr;
    axi_arready = 1'b1;
    advance_cycle();
    axi_arready = 1'b0;
    repeat (r_wait) advance_cycle();
    axi_rdata  = mem[addr[11:2]];
    axi_rvalid = 1'b1;
    assert (axi_rready === 1'b1) else begin
      $display("ERR rready: expected %h, got %h", 1'b1, axi_rready);
      errors++;
    end
    advance_cycle();
    axi_rvalid = 1'b0;
    check_fetch(addr);
  endtask

  initial begin : axi_memory
    @(posedge arst_n);
    advance_cycle();
    forever begin                                  // One transaction at a time.
      if (axi_awvalid || axi_wvalid) serve_write();
      else if (axi_arvalid) serve_read();
      else advance_cycle();
    end
  end

  initial begin
    arst_n      = 1'b0;
    axi_awready = 1'b0;
    axi_wready  = 1'b0;
    axi_bresp   = 2'b00;
    axi_bvalid  = 1'b0;
    axi_arready = 1'b0;
    axi_rdata   = '0;
    axi_rresp   = 2'b00;
    axi_rvalid  = 1'b0;
    rng_state   = 32'd76219;
    fetch_count = 0;
    stores_seen = 0;
    errors      = 0;
    cycles      = 0;
    last_fetch_addr = '0;
    last_word       = '0;
    build_tables();
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'hA500_0000 | (i << 2); // Opcode 0x29.
    for (int i = 0; i < N_PROG; i++) mem[i] = program_words[i];
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;
    while (stores_seen < N_STORES && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (stores_seen < N_STORES) begin
      $display("Timeout after %0d cycles, the stores did not all arrive (%0d of %0d)",
               cycles, stores_seen, N_STORES);
      errors++;
    end else begin
      repeat (DRAIN) @(posedge clk);               // Spin loop must not store again.
    end
    $display("Summary: %0d of %0d stores seen, %0d fetches, %0d errors",
             stores_seen, N_STORES, fetch_count, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
verilog/cpu_pkg.sv
verilog/ctrl_word_if.sv
verilog/microcode_rom.sv
verilog/microcode_sequencer.sv
verilog/datapath.sv
verilog/mem_axi_master.sv
verilog/cpu_top.sv
dv/tb_cpu_top.sv

// File: Bender.yml
package:
  name: microcode_cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/ctrl_word_if.sv
  - verilog/microcode_rom.sv
  - verilog/microcode_sequencer.sv
  - verilog/datapath.sv
  - verilog/mem_axi_master.sv
  - verilog/cpu_top.sv
  - target: simulation
    files:
      - dv/tb_cpu_top.sv
